//--- bench/reg_stack_checker.sv
`timescale 1ns/10ps
`include "regstack_params.svh"

module reg_stack_checker (
    input logic                      clock,
    input logic                      arst_n,
    input regstack_pkg::gpr_wb_t     gpr_wb,
    input regstack_pkg::reg_addr_t   rs1,
    input regstack_pkg::reg_addr_t   rs2,
    input regstack_pkg::xlen_t       rs1_value,
    input regstack_pkg::xlen_t       rs2_value,
    input regstack_pkg::trap_t       trap,
    input regstack_pkg::xlen_t       mepc,
    input regstack_pkg::csr_view_t   csr_view
);

    // x0 always reads zero
    x0_rs1_zero: assert property (@(posedge clock) disable iff (!arst_n)
        (rs1 == '0) |-> (rs1_value == '0))
        else $error("rs1 port returned a nonzero value for x0");

    x0_rs2_zero: assert property (@(posedge clock) disable iff (!arst_n)
        (rs2 == '0) |-> (rs2_value == '0))
        else $error("rs2 port returned a nonzero value for x0");

    // trap recorded one cycle later
    ecall_update: assert property (@(posedge clock) disable iff (!arst_n)
        trap.ecall |=> (mepc == $past(trap.pc)) && (csr_view.mcause == `RS_CAUSE_ECALL))
        else $error("ecall did not load mepc with the pc and mcause with the ecall cause");

    x0_write_dropped: assert property (@(posedge clock) disable iff (!arst_n)
        (gpr_wb.wen && (gpr_wb.addr == '0)) |=> ((rs1 != '0) || (rs1_value == '0)))
        else $error("write-back to x0 changed the value read from x0");

endmodule

bind reg_stack reg_stack_checker reg_stack_checker_inst (
    .clock     (clock),
    .arst_n    (arst_n),
    .gpr_wb    (gpr_wb),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .trap      (trap),
    .mepc      (mepc),
    .csr_view  (csr_view)
);

//--- bench/reg_stack_patterns.txt
# columns: op tag f1 f2 f3 expected, numbers in hex, unused fields 0
# G addr data | R addr | C wen data | S csr_addr | E pc wen data | A (a0 check)
R rst_x0        00  0        0        00000000
R rst_x1        01  0        0        00000000
R rst_x31       1f  0        0        00000000
A rst_a0        0   0        0        00000000
S rst_mepc      341 0        0        00000000
S rst_mcause    342 0        0        00000000
S rst_mstatus   300 0        0        00001808
S rst_mtvec     305 0        0        00000100
G wr_x1         01  a5a50001 0        00000000
R wr_x1         01  0        0        a5a50001
G wr_x31        1f  12345678 0        00000000
R wr_x31        1f  0        0        12345678
G wr_x10        0a  cafe0010 0        00000000
A wr_a0         0   0        0        cafe0010
R wr_x10        0a  0        0        cafe0010
R keep_x1       01  0        0        a5a50001
G wr_x0         00  ffffffff 0        00000000
R x0_zero       00  0        0        00000000
C wr_mepc       1   11110000 0        00000000
S wr_mepc       341 0        0        11110000
C wr_mcause     2   00000007 0        00000000
S wr_mcause     342 0        0        00000007
S keep_mepc     341 0        0        11110000
C wr_mstatus    4   00000008 0        00000000
S wr_mstatus    300 0        0        00000008
C wr_mtvec      8   00002000 0        00000000
S wr_mtvec      305 0        0        00002000
S keep_mcause   342 0        0        00000007
S unimpl_344    344 0        0        00000000
E ecall         00000400 0   0        00000000
S ecall_mepc    341 0        0        00000400
S ecall_mcause  342 0        0        0000000b
S ecall_mstatus 300 0        0        00000080
S ecall_mtvec   305 0        0        00002000
E ecall_prio    00000800 9   deadbeef 00000000
S prio_mepc     341 0        0        00000800
S prio_mtvec    305 0        0        deadbeef
S prio_mcause   342 0        0        0000000b
S prio_mstatus  300 0        0        00000000

//--- bench/reg_stack_tb.sv
`timescale 1ns/10ps
`include "regstack_params.svh"

module reg_stack_tb;

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 16;
    localparam int    MARGIN       = 50;
    localparam string PATTERN_FILE = "bench/reg_stack_patterns.txt";

    // one parsed line of the pattern file
    typedef struct packed {
        logic [7:0]          op;
        regstack_pkg::xlen_t f1;
        regstack_pkg::xlen_t f2;
        regstack_pkg::xlen_t f3;
        regstack_pkg::xlen_t expected;
    } pattern_t;

    logic                      clock;
    logic                      arst_n;
    regstack_pkg::gpr_wb_t     gpr_wb;
    regstack_pkg::reg_addr_t   rs1;
    regstack_pkg::reg_addr_t   rs2;
    regstack_pkg::csr_addr_t   csr_addr;
    regstack_pkg::csr_wr_t     csr_wr;
    regstack_pkg::trap_t       trap;
    regstack_pkg::xlen_t       rs1_value;
    regstack_pkg::xlen_t       rs2_value;
    regstack_pkg::xlen_t       a0_value;
    regstack_pkg::xlen_t       csr_rdata;
    regstack_pkg::xlen_t       mepc;
    regstack_pkg::xlen_t       mtvec;

    pattern_t patterns [$];
    string    tags [$];

    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = RESET_CYCLES + MARGIN;   // raised once the file is read

    reg_stack reg_stack_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .gpr_wb    (gpr_wb),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr_addr  (csr_addr),
        .csr_wr    (csr_wr),
        .trap      (trap),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .a0_value  (a0_value),
        .csr_rdata (csr_rdata),
        .mepc      (mepc),
        .mtvec     (mtvec)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // ====================================================================
    // helpers
    // ====================================================================
    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input regstack_pkg::xlen_t expected,
                               input regstack_pkg::xlen_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic clear_inputs();
        gpr_wb   = '0;
        rs1      = '0;
        rs2      = '0;
        csr_addr = '0;
        csr_wr   = '0;
        trap     = '0;
    endtask

    task automatic load_patterns(output bit ok);
        int                  fd;
        int                  rc;
        int                  n;
        string               line;
        string               op_s;
        string               tag;
        regstack_pkg::xlen_t f1;
        regstack_pkg::xlen_t f2;
        regstack_pkg::xlen_t f3;
        regstack_pkg::xlen_t exp_value;
        pattern_t            p;

        ok = 1'b0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("could not open pattern file %s", PATTERN_FILE);
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h %h",
                                op_s, tag, f1, f2, f3, exp_value);
                    if (n == 6) begin
                        p.op       = op_s.getc(0);
                        p.f1       = f1;
                        p.f2       = f2;
                        p.f3       = f3;
                        p.expected = exp_value;
                        patterns.push_back(p);
                        tags.push_back(tag);
                    end
                end
            end
            $fclose(fd);
            if (patterns.size() == 0) begin
                $display("pattern file %s holds no operations", PATTERN_FILE);
            end else begin
                ok = 1'b1;
            end
        end
        cycle_limit = RESET_CYCLES + 2 * patterns.size() + MARGIN;
    endtask

    // drive on the falling edge and check just before the next one
    task automatic run_line(input int idx);
        pattern_t p;
        string    tag;

        p   = patterns[idx];
        tag = tags[idx];
        @(negedge clock);
        clear_inputs();
        case (p.op)
            "G": begin
                gpr_wb.wen  = 1'b1;
                gpr_wb.addr = p.f1[`RS_AW-1:0];
                gpr_wb.data = p.f2;
            end
            "R": begin
                rs1 = p.f1[`RS_AW-1:0];
                rs2 = p.f1[`RS_AW-1:0];
            end
            "C": begin
                csr_wr.wen  = p.f1[3:0];
                csr_wr.data = p.f2;
            end
            "S": begin
                csr_addr = p.f1[`RS_CSR_AW-1:0];
            end
            "E": begin
                trap.ecall  = 1'b1;
                trap.pc     = p.f1;
                csr_wr.wen  = p.f2[3:0];   // optional write in the same cycle
                csr_wr.data = p.f3;
            end
            "A": begin
            end
            default: begin
                $display("unknown operation on pattern line %0d (test %s)", idx, tag);
                error_count++;
            end
        endcase
        @(posedge clock);
        #(CLK_PERIOD / 2 - 1);
        case (p.op)
            "R": begin
                check_value({tag, " rs1"}, p.expected, rs1_value);
                check_value({tag, " rs2"}, p.expected, rs2_value);
            end
            "S": begin
                check_value({tag, " csr_rdata"}, p.expected, csr_rdata);
                if (csr_addr == `RS_CSR_MEPC) begin
                    check_value({tag, " mepc out"}, p.expected, mepc);
                end
                if (csr_addr == `RS_CSR_MTVEC) begin
                    check_value({tag, " mtvec out"}, p.expected, mtvec);
                end
            end
            "A": begin
                check_value({tag, " a0"}, p.expected, a0_value);
            end
            default: begin
            end
        endcase
    endtask

    // ====================================================================
    // main sequence
    // ====================================================================
    initial begin
        bit loaded;

        clear_inputs();
        arst_n = 1'b0;
        load_patterns(loaded);
        if (!loaded) begin
            error_count++;
            finish_run();
        end else begin
            repeat (RESET_CYCLES) @(posedge clock);
            @(negedge clock);
            arst_n = 1'b1;
            foreach (patterns[i]) begin
                run_line(i);
            end
            finish_run();
        end
    end

    // watchdog
    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("run timed out after %0d clock cycles", cycle_count);
        error_count++;
        finish_run();
    end

endmodule

//--- compile.f
+incdir+include
src/regstack_pkg.sv
src/gpr_file.sv
src/csr_file.sv
src/reg_stack.sv
bench/reg_stack_checker.sv
bench/reg_stack_tb.sv

//--- include/regstack_params.svh
`ifndef REGSTACK_PARAMS_SVH
`define REGSTACK_PARAMS_SVH

// widths
`define RS_XLEN            32
`define RS_AW              5
`define RS_CSR_AW          12

// machine csr addresses
`define RS_CSR_MEPC        12'h341
`define RS_CSR_MCAUSE      12'h342
`define RS_CSR_MSTATUS     12'h300
`define RS_CSR_MTVEC       12'h305

// reset values
`define RS_MTVEC_RESET     32'h0000_0100
`define RS_MSTATUS_RESET   32'h0000_1808   // mpp = machine, mie set

`define RS_CAUSE_ECALL     32'd11          // environment call from m-mode

`endif

//--- run.sh
#!/usr/bin/env bash
# Build the reg_stack testbench with Verilator, run it and judge the log.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=reg_stack_sim
log_file=sim.log
fail_msg='*** TEST FAILED ***'

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f compile.f \
    --top-module reg_stack_tb \
    -Mdir "$build_dir" \
    -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "$fail_msg" "$log_file"; then
    echo "failure reported in $log_file"
    exit 1
fi

if ! grep -q "checks:" "$log_file"; then
    echo "simulation ended without a closing summary"
    exit 1
fi

echo "simulation finished cleanly, log in $log_file"
exit 0

//--- src/csr_file.sv
`timescale 1ns/10ps
`include "regstack_params.svh"

module csr_file (
    input  logic                      clock,
    input  logic                      arst_n,

    input  regstack_pkg::csr_wr_t     wr,
    input  regstack_pkg::trap_t       trap,

    output regstack_pkg::csr_view_t   view
);

    // mstatus fields touched by a trap
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;

    regstack_pkg::xlen_t mepc_q;
    regstack_pkg::xlen_t mcause_q;
    regstack_pkg::xlen_t mstatus_q;
    regstack_pkg::xlen_t mtvec_q;

    regstack_pkg::xlen_t mstatus_trap;

    logic wen_mepc;
    logic wen_mcause;
    logic wen_mstatus;
    logic wen_mtvec;

    assign wen_mepc    = wr.wen[regstack_pkg::CSR_BIT_MEPC];
    assign wen_mcause  = wr.wen[regstack_pkg::CSR_BIT_MCAUSE];
    assign wen_mstatus = wr.wen[regstack_pkg::CSR_BIT_MSTATUS];
    assign wen_mtvec   = wr.wen[regstack_pkg::CSR_BIT_MTVEC];

    // mie -> mpie, then mie cleared; other bits kept
    always_comb begin
        mstatus_trap           = mstatus_q;
        mstatus_trap[MPIE_BIT] = mstatus_q[MIE_BIT];
        mstatus_trap[MIE_BIT]  = 1'b0;
    end

    // ===================================================================
    // trap state, ecall has priority over software writes
    // ===================================================================
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mepc_q <= '0;
        end else if (trap.ecall) begin
            mepc_q <= trap.pc;
        end else if (wen_mepc) begin
            mepc_q <= wr.data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mcause_q <= '0;
        end else if (trap.ecall) begin
            mcause_q <= `RS_CAUSE_ECALL;
        end else if (wen_mcause) begin
            mcause_q <= wr.data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_q <= `RS_MSTATUS_RESET;
        end else if (trap.ecall) begin
            mstatus_q <= mstatus_trap;
        end else if (wen_mstatus) begin
            mstatus_q <= wr.data;
        end
    end

    // ===================================================================
    // trap vector, software only
    // ===================================================================
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mtvec_q <= `RS_MTVEC_RESET;
        end else if (wen_mtvec) begin
            mtvec_q <= wr.data;   // not blocked by ecall
        end
    end

    assign view.mepc    = mepc_q;
    assign view.mcause  = mcause_q;
    assign view.mstatus = mstatus_q;
    assign view.mtvec   = mtvec_q;

endmodule

//--- src/gpr_file.sv
`timescale 1ns/10ps
`include "regstack_params.svh"

module gpr_file (
    input  logic                    clock,
    input  logic                    arst_n,

    input  regstack_pkg::gpr_wb_t   wb,
    input  regstack_pkg::reg_addr_t rs1,
    input  regstack_pkg::reg_addr_t rs2,

    output regstack_pkg::xlen_t     rs1_value,
    output regstack_pkg::xlen_t     rs2_value,
    output regstack_pkg::xlen_t     a0_value
);

    localparam int NREGS  = 1 << `RS_AW;
    localparam int A0_IDX = 10;              // abi name a0

    // ===================================================================
    // storage
    // ===================================================================
    regstack_pkg::xlen_t regs [1:NREGS-1];   // x0 is not stored

    logic wr_en;

    // writes to x0 are dropped here
    assign wr_en = wb.wen && (wb.addr != '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // ===================================================================
    // read ports
    // ===================================================================

    // async lookup, x0 hard-wired to zero
    function automatic regstack_pkg::xlen_t read_reg(
        input regstack_pkg::reg_addr_t addr
    );
        regstack_pkg::xlen_t value;

        value = '0;
        for (int i = 1; i < NREGS; i++) begin
            if (addr == regstack_pkg::reg_addr_t'(i)) begin
                value = regs[i];
            end
        end
        return value;
    endfunction

    always_comb begin
        rs1_value = read_reg(rs1);
    end

    always_comb begin
        rs2_value = read_reg(rs2);
    end

    // a0 tap for the outside world
    assign a0_value = regs[A0_IDX];

endmodule

//--- src/reg_stack.sv
`timescale 1ns/10ps
`include "regstack_params.svh"

module reg_stack (
    input  logic                      clock,
    input  logic                      arst_n,

    // gpr side
    input  regstack_pkg::gpr_wb_t     gpr_wb,
    input  regstack_pkg::reg_addr_t   rs1,
    input  regstack_pkg::reg_addr_t   rs2,

    // csr side
    input  regstack_pkg::csr_addr_t   csr_addr,
    input  regstack_pkg::csr_wr_t     csr_wr,
    input  regstack_pkg::trap_t       trap,

    output regstack_pkg::xlen_t       rs1_value,
    output regstack_pkg::xlen_t       rs2_value,
    output regstack_pkg::xlen_t       a0_value,
    output regstack_pkg::xlen_t       csr_rdata,
    output regstack_pkg::xlen_t       mepc,       // mret target
    output regstack_pkg::xlen_t       mtvec       // trap entry
);

    regstack_pkg::gpr_wb_t   wb_masked;
    regstack_pkg::csr_view_t csr_view;

    // ===================================================================
    // write-back to x0 carries zero data
    // ===================================================================
    always_comb begin
        wb_masked = gpr_wb;
        if (gpr_wb.addr == '0) begin
            wb_masked.data = '0;
        end
    end

    // ===================================================================
    // csr read decode
    // ===================================================================
    always_comb begin
        case (csr_addr)
            `RS_CSR_MEPC:    csr_rdata = csr_view.mepc;
            `RS_CSR_MCAUSE:  csr_rdata = csr_view.mcause;
            `RS_CSR_MSTATUS: csr_rdata = csr_view.mstatus;
            `RS_CSR_MTVEC:   csr_rdata = csr_view.mtvec;
            default:         csr_rdata = '0;   // unimplemented
        endcase
    end

    // redirect paths for the core
    assign mepc  = csr_view.mepc;
    assign mtvec = csr_view.mtvec;

    // ===================================================================
    // storage
    // ===================================================================
    csr_file csr_file_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .wr        (csr_wr),
        .trap      (trap),
        .view      (csr_view)
    );

    gpr_file gpr_file_inst (
        .clock     (clock),
        .arst_n    (arst_n),
        .wb        (wb_masked),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .a0_value  (a0_value)
    );

endmodule

//--- src/regstack_pkg.sv
`include "regstack_params.svh"

package regstack_pkg;

    // ===================================================================
    // plain vectors
    // ===================================================================
    typedef logic [`RS_XLEN-1:0]   xlen_t;
    typedef logic [`RS_AW-1:0]     reg_addr_t;
    typedef logic [`RS_CSR_AW-1:0] csr_addr_t;
    typedef logic [3:0]            csr_wen_t;   // one-hot, one bit per csr

    // bit positions inside csr_wen_t
    localparam int CSR_BIT_MEPC    = 0;
    localparam int CSR_BIT_MCAUSE  = 1;
    localparam int CSR_BIT_MSTATUS = 2;
    localparam int CSR_BIT_MTVEC   = 3;

    // ===================================================================
    // grouped signals
    // ===================================================================
    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        xlen_t     data;
    } gpr_wb_t;

    typedef struct packed {
        csr_wen_t wen;
        xlen_t    data;
    } csr_wr_t;

    // ecall request with the pc of the faulting instruction
    typedef struct packed {
        logic  ecall;
        xlen_t pc;
    } trap_t;

    typedef struct packed {
        xlen_t mepc;
        xlen_t mcause;
        xlen_t mstatus;
        xlen_t mtvec;
    } csr_view_t;

endpackage
